// File: vlog.f
+incdir+test
design/cpu_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu.sv
test/tb_cpu.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_cpu -f vlog.f -o tb_cpu

run: compile
	./obj_dir/tb_cpu > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic inst_t rtype_inst(input funct_t fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic inst_t itype_inst(input opcode_t op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t sign_extend(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
endfunction

task automatic push_const(input reg_addr_t r, input word_t value);
    prog.push_back(itype_inst(OP_LUI, r, 5'd0, value[31:16]));
    prog.push_back(itype_inst(OP_ORI, r, r, value[15:0]));
endtask

// sentinel store, then a branch to itself with a nop delay slot
task automatic finish_program();
    prog.push_back(itype_inst(OP_SW, 5'd0, 5'd0, 16'h00fc));
    prog.push_back(itype_inst(OP_BEQ, 5'd0, 5'd0, 16'hffff));
    prog.push_back(32'h0000_0000);
endtask

task automatic load_program();
    int base;
    base = int'(RESET_PC / 4);
    for (int i = 0; i < 1024; i++) begin
        rom[i] = '0;
    end
    foreach (prog[i]) begin
        rom[base + i] = prog[i];
    end
endtask

task automatic compare_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic compare_addr(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("Fail %s address: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic compare_count(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
        errors++;
        $display("Fail %s count: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
endtask

// reset, clear the RAM, release and wait for the sentinel store
task automatic run_program(input string name);
    int cycles;
    int max_cycles;
    max_cycles = prog.size() * 40;
    load_program();
    @(posedge clk);
    #1;
    rst_n_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        #1;
        clear_ram = (i == 0);
        compare_flag({name, " ram_we_o in reset"}, 1'b0, ram_we_o);
        compare_flag({name, " ram_re_o in reset"}, 1'b0, ram_re_o);
        compare_flag({name, " rom_ce_o in reset"}, 1'b0, rom_ce_o);
    end
    rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    compare_flag({name, " ram_we_o after reset"}, 1'b0, ram_we_o);
    compare_flag({name, " ram_re_o after reset"}, 1'b0, ram_re_o);
    compare_flag({name, " first rom_ce_o"}, 1'b1, rom_ce_o);
    compare_addr({name, " first fetch"}, RESET_PC, rom_addr_o);
    cycles = 0;
    while (!sentinel_seen && cycles < max_cycles) begin
        @(negedge clk);
        cycles++;
    end
    if (!sentinel_seen) begin
        errors++;
        $display("%s: no store to the sentinel address within %0d cycles", name, max_cycles);
    end
endtask

task automatic alu_test(input word_t a, input word_t b, input logic [15:0] k,
                        input logic with_stall);
    string  name;
    funct_t fns [6];
    word_t  expected [7];
    name = with_stall ? "alu with bus stall" : "alu";
    fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    prog.delete();
    push_const(5'd1, a);
    push_const(5'd2, b);
    for (int i = 0; i < 6; i++) begin
        prog.push_back(rtype_inst(fns[i], 5'd3, 5'd1, 5'd2));
        prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'(i * 4)));
    end
    prog.push_back(itype_inst(OP_ADDIU, 5'd3, 5'd1, k));
    prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'h0018));
    finish_program();
    stall_en = with_stall;
    run_program(name);
    stall_en = 1'b0;
    expected[0] = a + b;
    expected[1] = a - b;
    expected[2] = a & b;
    expected[3] = a | b;
    expected[4] = a ^ b;
    // signs differ means the negative one is smaller
    if (a[31] != b[31]) begin
        expected[5] = {31'd0, a[31]};
    end else begin
        expected[5] = (a < b) ? 32'd1 : 32'd0;
    end
    expected[6] = a + sign_extend(k);
    for (int i = 0; i < 7; i++) begin
        compare_word(name, expected[i], ram[i]);
        compare_addr(name, word_t'(i * 4), store_log[i]);
    end
    compare_addr(name, 32'h0000_00fc, store_log[7]);
    compare_count(name, 8, store_log.size());
endtask

task automatic stall_test(input word_t a, input word_t b, input logic [15:0] k);
    word_t saved_ram [0:255];
    word_t saved_log [$];
    alu_test(a, b, k, 1'b0);
    saved_ram = ram;
    saved_log = store_log;
    alu_test(a, b, k, 1'b1);
    for (int i = 0; i < 256; i++) begin
        compare_word("bus stall ram", saved_ram[i], ram[i]);
    end
    compare_count("bus stall log", saved_log.size(), store_log.size());
    foreach (saved_log[i]) begin
        compare_addr("bus stall log", saved_log[i], store_log[i]);
    end
endtask

task automatic forwarding_test(input word_t a, input logic [15:0] k);
    word_t e2;
    word_t e3;
    word_t e4;
    word_t e5;
    prog.delete();
    push_const(5'd1, a);
    // each instruction reads the one just before it
    prog.push_back(rtype_inst(FN_ADDU, 5'd2, 5'd1, 5'd1));
    prog.push_back(rtype_inst(FN_SUBU, 5'd3, 5'd2, 5'd1));
    prog.push_back(rtype_inst(FN_XOR, 5'd4, 5'd3, 5'd2));
    prog.push_back(itype_inst(OP_ADDIU, 5'd5, 5'd4, k));
    prog.push_back(rtype_inst(FN_OR, 5'd6, 5'd5, 5'd1));
    prog.push_back(itype_inst(OP_SW, 5'd6, 5'd0, 16'h0040));
    finish_program();
    run_program("forwarding");
    e2 = a + a;
    e3 = e2 - a;
    e4 = e3 ^ e2;
    e5 = e4 + sign_extend(k);
    compare_word("forwarding", e5 | a, ram[16]);
    compare_count("forwarding", 2, store_log.size());
endtask

task automatic load_use_test(input word_t a, input logic [15:0] k);
    prog.delete();
    push_const(5'd1, a);
    prog.push_back(itype_inst(OP_SW, 5'd1, 5'd0, 16'h0080));
    prog.push_back(itype_inst(OP_LW, 5'd2, 5'd0, 16'h0080));
    prog.push_back(itype_inst(OP_ADDIU, 5'd3, 5'd2, k));
    prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'h0084));
    finish_program();
    run_program("load-use");
    compare_word("load-use stored", a, ram[32]);
    compare_word("load-use sum", a + sign_extend(k), ram[33]);
    compare_count("load-use", 3, store_log.size());
    // the single lw reads the RAM once
    compare_count("load-use reads", 1, load_log.size());
    compare_addr("load-use read", 32'h0000_0080, load_log[0]);
endtask

task automatic branch_test();
    word_t expected_log [4];
    expected_log = '{32'h90, 32'ha0, 32'ha4, 32'hfc};
    prog.delete();
    prog.push_back(itype_inst(OP_ADDIU, 5'd1, 5'd0, 16'h0005));
    prog.push_back(itype_inst(OP_ADDIU, 5'd2, 5'd0, 16'h0005));
    prog.push_back(itype_inst(OP_ADDIU, 5'd3, 5'd0, 16'h0077));
    // taken branch to three words past the delay slot
    prog.push_back(itype_inst(OP_BEQ, 5'd2, 5'd1, 16'h0003));
    prog.push_back(itype_inst(OP_SW, 5'd1, 5'd0, 16'h0090));
    prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'h0094));
    prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'h0098));
    // not taken so it falls through
    prog.push_back(itype_inst(OP_BNE, 5'd2, 5'd1, 16'h0003));
    prog.push_back(itype_inst(OP_SW, 5'd2, 5'd0, 16'h00a0));
    prog.push_back(itype_inst(OP_SW, 5'd3, 5'd0, 16'h00a4));
    finish_program();
    run_program("branch");
    compare_word("branch delay slot", 32'd5, ram[36]);
    compare_word("branch skipped 0x94", fill_value(37), ram[37]);
    compare_word("branch skipped 0x98", fill_value(38), ram[38]);
    compare_word("bne delay slot", 32'd5, ram[40]);
    compare_word("bne fall through", 32'h77, ram[41]);
    compare_count("branch", 4, store_log.size());
    for (int i = 0; i < 4; i++) begin
        compare_addr("branch", expected_log[i], store_log[i]);
    end
endtask

task automatic reset_test();
    prog.delete();
    prog.push_back(itype_inst(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
    prog.push_back(itype_inst(OP_SW, 5'd0, 5'd0, 16'h00b0));
    finish_program();
    run_program("reset");
    compare_word("reset register 0", 32'd0, ram[44]);
    compare_count("reset", 2, store_log.size());
endtask

`endif

// File: test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam inst_addr_t RESET_PC = 32'h0000_0100;
    // program words over all tests including the stall rerun
    localparam int TOTAL_WORDS = 80;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 500;

    logic       clk = 1'b0;
    logic       rst_n_i = 1'b0;
    logic       bus_stall_i = 1'b0;
    inst_t      rom_data_i;
    inst_addr_t rom_addr_o;
    logic       rom_ce_o;
    word_t      ram_data_i;
    word_t      ram_addr_o;
    word_t      ram_data_o;
    logic       ram_we_o;
    logic       ram_re_o;

    inst_t rom [0:1023];
    word_t ram [0:255];
    word_t store_log [$];
    word_t load_log [$];
    inst_t prog [$];
    logic  sentinel_seen = 1'b0;
    logic  clear_ram = 1'b0;
    logic  stall_en = 1'b0;
    int    errors = 0;
    int    checks = 0;

    cpu #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk,
        .rst_n_i,
        .rom_data_i,
        .rom_addr_o,
        .rom_ce_o,
        .ram_data_i,
        .ram_addr_o,
        .ram_data_o,
        .ram_we_o,
        .ram_re_o,
        .bus_stall_i
    );

    // both memories answer combinationally
    assign rom_data_i = rom[rom_addr_o[11:2]];
    assign ram_data_i = ram[ram_addr_o[9:2]];

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic word_t fill_value(input int idx);
        word_t addr;
        addr = word_t'(idx) << 2;
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f96;
    endfunction

    // data RAM takes a store or a read only on an edge without bus stall
    always @(posedge clk) begin
        if (clear_ram) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= fill_value(i);
            end
            store_log.delete();
            load_log.delete();
            sentinel_seen <= 1'b0;
        end else begin
            if (ram_we_o && !bus_stall_i) begin
                ram[ram_addr_o[9:2]] <= ram_data_o;
                store_log.push_back(ram_addr_o);
                if (ram_addr_o == 32'h0000_00fc) begin
                    sentinel_seen <= 1'b1;
                end
            end
            if (ram_re_o && !bus_stall_i) begin
                load_log.push_back(ram_addr_o);
            end
        end
    end

    // random bus stall, about one cycle in three
    always @(posedge clk) begin
        #1;
        bus_stall_i = stall_en && ($urandom_range(0, 2) == 0);
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Watchdog: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    `include "tb_tasks.svh"

    initial begin
        word_t a;
        word_t b;
        word_t k;
        void'($urandom(27952));
        a = $urandom();
        b = $urandom();
        k = $urandom();
        reset_test();
        stall_test(a, b, k[15:0]);
        a = $urandom();
        k = $urandom();
        forwarding_test(a, k[15:0]);
        a = $urandom();
        k = $urandom();
        load_use_test(a, k[15:0]);
        branch_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter cpu_pkg::inst_addr_t RESET_PC = '0
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire cpu_pkg::inst_t      rom_data_i,
    output cpu_pkg::inst_addr_t      rom_addr_o,
    output logic                     rom_ce_o,
    input  wire cpu_pkg::word_t      ram_data_i,
    output cpu_pkg::word_t           ram_addr_o,
    output cpu_pkg::word_t           ram_data_o,
    output logic                     ram_we_o,
    output logic                     ram_re_o,
    input  wire                      bus_stall_i
);
    import cpu_pkg::*;

    // fetch and decode
    inst_addr_t id_pc;
    inst_t      id_inst;
    logic       branch_taken;
    inst_addr_t branch_target;
    logic       id_stall;
    logic       id_hold;

    // register file
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_we;

    // decode to execute
    oper_t     ex_oper;
    word_t     ex_src1;
    word_t     ex_src2;
    word_t     ex_store_data;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_fwd_wdata;
    logic      ex_is_load;

    // execute to memory
    oper_t     mem_oper;
    word_t     mem_result;
    word_t     mem_store_data;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_fwd_wdata;

    // write-back
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    // front end waits on a load-use hazard too, the back end only on the bus
    assign id_hold = bus_stall_i | id_stall;
    assign rf_we   = wb_we & ~bus_stall_i;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_stage_instance (
        .clk,
        .rst_n_i,
        .stall_i(id_hold),
        .branch_taken_i(branch_taken),
        .branch_target_i(branch_target),
        .rom_data_i,
        .rom_addr_o,
        .rom_ce_o,
        .id_pc_o(id_pc),
        .id_inst_o(id_inst)
    );

    register_file register_file_instance (
        .clk,
        .rst_n_i,
        .we_i(rf_we),
        .waddr_i(wb_waddr),
        .wdata_i(wb_wdata),
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2)
    );

    decode_stage decode_stage_instance (
        .clk,
        .rst_n_i,
        .hold_i(id_hold),
        .bus_stall_i,
        .pc_i(id_pc),
        .inst_i(id_inst),
        .raddr1_o(rf_raddr1),
        .raddr2_o(rf_raddr2),
        .rdata1_i(rf_rdata1),
        .rdata2_i(rf_rdata2),
        .ex_we_i(ex_we),
        .ex_waddr_i(ex_waddr),
        .ex_wdata_i(ex_fwd_wdata),
        .ex_is_load_i(ex_is_load),
        .mem_we_i(mem_we),
        .mem_waddr_i(mem_waddr),
        .mem_wdata_i(mem_fwd_wdata),
        .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .id_stall_o(id_stall),
        .ex_oper_o(ex_oper),
        .ex_src1_o(ex_src1),
        .ex_src2_o(ex_src2),
        .ex_store_data_o(ex_store_data),
        .ex_we_o(ex_we),
        .ex_waddr_o(ex_waddr)
    );

    execute_stage execute_stage_instance (
        .clk,
        .rst_n_i,
        .stall_i(bus_stall_i),
        .oper_i(ex_oper),
        .src1_i(ex_src1),
        .src2_i(ex_src2),
        .store_data_i(ex_store_data),
        .we_i(ex_we),
        .waddr_i(ex_waddr),
        .fwd_wdata_o(ex_fwd_wdata),
        .is_load_o(ex_is_load),
        .mem_oper_o(mem_oper),
        .mem_result_o(mem_result),
        .mem_store_data_o(mem_store_data),
        .mem_we_o(mem_we),
        .mem_waddr_o(mem_waddr)
    );

    memory_stage memory_stage_instance (
        .clk,
        .rst_n_i,
        .stall_i(bus_stall_i),
        .oper_i(mem_oper),
        .result_i(mem_result),
        .store_data_i(mem_store_data),
        .we_i(mem_we),
        .waddr_i(mem_waddr),
        .ram_data_i,
        .ram_addr_o,
        .ram_data_o,
        .ram_we_o,
        .ram_re_o,
        .fwd_wdata_o(mem_fwd_wdata),
        .wb_we_o(wb_we),
        .wb_waddr_o(wb_waddr),
        .wb_wdata_o(wb_wdata)
    );

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     stall_i,
    input  wire cpu_pkg::oper_t     oper_i,
    input  wire cpu_pkg::word_t     result_i,
    input  wire cpu_pkg::word_t     store_data_i,
    input  wire                     we_i,
    input  wire cpu_pkg::reg_addr_t waddr_i,
    input  wire cpu_pkg::word_t     ram_data_i,
    output cpu_pkg::word_t          ram_addr_o,
    output cpu_pkg::word_t          ram_data_o,
    output logic                    ram_we_o,
    output logic                    ram_re_o,
    output cpu_pkg::word_t          fwd_wdata_o,
    output logic                    wb_we_o,
    output cpu_pkg::reg_addr_t      wb_waddr_o,
    output cpu_pkg::word_t          wb_wdata_o
);
    import cpu_pkg::*;

    logic is_load;
    logic is_store;

    assign is_load  = (oper_i == OPER_LW);
    assign is_store = (oper_i == OPER_SW);

    // request held steady by the frozen execute/memory register
    assign ram_addr_o = result_i;
    assign ram_data_o = store_data_i;
    assign ram_we_o   = is_store;
    assign ram_re_o   = is_load;

    // load data comes back in the same cycle
    assign fwd_wdata_o = is_load ? ram_data_i : result_i;

    // memory/write-back register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_o    <= 1'b0;
            wb_waddr_o <= '0;
        end else if (!stall_i) begin
            wb_we_o    <= we_i;
            wb_waddr_o <= waddr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_wdata_o <= fwd_wdata_o;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     stall_i,
    input  wire cpu_pkg::oper_t     oper_i,
    input  wire cpu_pkg::word_t     src1_i,
    input  wire cpu_pkg::word_t     src2_i,
    input  wire cpu_pkg::word_t     store_data_i,
    input  wire                     we_i,
    input  wire cpu_pkg::reg_addr_t waddr_i,
    output cpu_pkg::word_t          fwd_wdata_o,
    output logic                    is_load_o,
    output cpu_pkg::oper_t          mem_oper_o,
    output cpu_pkg::word_t          mem_result_o,
    output cpu_pkg::word_t          mem_store_data_o,
    output logic                    mem_we_o,
    output cpu_pkg::reg_addr_t      mem_waddr_o
);
    import cpu_pkg::*;

    word_t result;

    always_comb begin
        case (oper_i)
            // loads and stores use the adder for base plus offset
            OPER_ADDU, OPER_LW, OPER_SW: result = src1_i + src2_i;
            OPER_SUBU: result = src1_i - src2_i;
            OPER_AND:  result = src1_i & src2_i;
            OPER_OR:   result = src1_i | src2_i;
            OPER_XOR:  result = src1_i ^ src2_i;
            OPER_SLT:  result = {31'd0, $signed(src1_i) < $signed(src2_i)};
            // upper half already placed by decode
            OPER_LUI:  result = src2_i;
            default:   result = '0;
        endcase
    end

    assign fwd_wdata_o = result;
    assign is_load_o   = (oper_i == OPER_LW);

    // execute/memory register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_oper_o  <= OPER_NOP;
            mem_we_o    <= 1'b0;
            mem_waddr_o <= '0;
        end else if (!stall_i) begin
            mem_oper_o  <= oper_i;
            mem_we_o    <= we_i;
            mem_waddr_o <= waddr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_result_o     <= result;
            mem_store_data_o <= store_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      hold_i,
    input  wire                      bus_stall_i,
    input  wire cpu_pkg::inst_addr_t pc_i,
    input  wire cpu_pkg::inst_t      inst_i,
    output cpu_pkg::reg_addr_t       raddr1_o,
    output cpu_pkg::reg_addr_t       raddr2_o,
    input  wire cpu_pkg::word_t      rdata1_i,
    input  wire cpu_pkg::word_t      rdata2_i,
    input  wire                      ex_we_i,
    input  wire cpu_pkg::reg_addr_t  ex_waddr_i,
    input  wire cpu_pkg::word_t      ex_wdata_i,
    input  wire                      ex_is_load_i,
    input  wire                      mem_we_i,
    input  wire cpu_pkg::reg_addr_t  mem_waddr_i,
    input  wire cpu_pkg::word_t      mem_wdata_i,
    output logic                     branch_taken_o,
    output cpu_pkg::inst_addr_t      branch_target_o,
    output logic                     id_stall_o,
    output cpu_pkg::oper_t           ex_oper_o,
    output cpu_pkg::word_t           ex_src1_o,
    output cpu_pkg::word_t           ex_src2_o,
    output cpu_pkg::word_t           ex_store_data_o,
    output logic                     ex_we_o,
    output cpu_pkg::reg_addr_t       ex_waddr_o
);
    import cpu_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm_sext;
    word_t     imm_zext;
    word_t     op1;
    word_t     op2;
    word_t     src2;
    oper_t     oper;
    logic      we;
    reg_addr_t waddr;
    logic      use_rs;
    logic      use_rt;

    // execute has the newest value, then memory, then the register file
    function automatic word_t forward(input reg_addr_t addr, input word_t rf_data);
        if (addr == 5'd0) begin
            return '0;
        end else if (ex_we_i && ex_waddr_i == addr) begin
            return ex_wdata_i;
        end else if (mem_we_i && mem_waddr_i == addr) begin
            return mem_wdata_i;
        end
        return rf_data;
    endfunction

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'h0000, inst_i[15:0]};
    assign raddr1_o = rs;
    assign raddr2_o = rt;

    always_comb begin
        op1 = forward(rs, rdata1_i);
        op2 = forward(rt, rdata2_i);
    end

    always_comb begin
        oper   = OPER_NOP;
        src2   = op2;
        we     = 1'b0;
        waddr  = rt;
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                waddr  = rd;
                use_rs = 1'b1;
                use_rt = 1'b1;
                we     = 1'b1;
                case (funct)
                    FN_ADDU: oper = OPER_ADDU;
                    FN_SUBU: oper = OPER_SUBU;
                    FN_AND:  oper = OPER_AND;
                    FN_OR:   oper = OPER_OR;
                    FN_XOR:  oper = OPER_XOR;
                    FN_SLT:  oper = OPER_SLT;
                    default: we = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                oper   = OPER_ADDU;
                src2   = imm_sext;
                we     = 1'b1;
                use_rs = 1'b1;
            end
            OP_ORI: begin
                oper   = OPER_OR;
                src2   = imm_zext;
                we     = 1'b1;
                use_rs = 1'b1;
            end
            OP_LUI: begin
                oper = OPER_LUI;
                src2 = {inst_i[15:0], 16'h0000};
                we   = 1'b1;
            end
            OP_LW: begin
                oper   = OPER_LW;
                src2   = imm_sext;
                we     = 1'b1;
                use_rs = 1'b1;
            end
            OP_SW: begin
                oper   = OPER_SW;
                src2   = imm_sext;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            default: begin
                oper = OPER_NOP;
            end
        endcase
    end

    // branch compare on forwarded operands, target relative to the delay slot
    assign branch_taken_o  = (opcode == OP_BEQ && op1 == op2) ||
                             (opcode == OP_BNE && op1 != op2);
    assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

    // a load in execute has no data yet
    assign id_stall_o = ex_is_load_i && ex_we_i && ex_waddr_i != 5'd0 &&
                        ((use_rs && rs == ex_waddr_i) || (use_rt && rt == ex_waddr_i));

    // decode/execute register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_oper_o  <= OPER_NOP;
            ex_we_o    <= 1'b0;
            ex_waddr_o <= '0;
        end else if (!bus_stall_i) begin
            // decode holds, so a bubble goes on
            if (hold_i) begin
                ex_oper_o  <= OPER_NOP;
                ex_we_o    <= 1'b0;
                ex_waddr_o <= '0;
            end else begin
                ex_oper_o  <= oper;
                ex_we_o    <= we;
                ex_waddr_o <= waddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!bus_stall_i) begin
            ex_src1_o       <= op1;
            ex_src2_o       <= src2;
            ex_store_data_o <= op2;
        end
    end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    we_i,
    input  wire cpu_pkg::reg_addr_t waddr_i,
    input  wire cpu_pkg::word_t    wdata_i,
    input  wire cpu_pkg::reg_addr_t raddr1_i,
    input  wire cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t         rdata1_o,
    output cpu_pkg::word_t         rdata2_o
);
    import cpu_pkg::*;

    word_t regs [0:31];

    // $0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees the value being written back
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::inst_addr_t RESET_PC = '0
) (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     stall_i,
    input  wire                     branch_taken_i,
    input  wire cpu_pkg::inst_addr_t branch_target_i,
    input  wire cpu_pkg::inst_t     rom_data_i,
    output cpu_pkg::inst_addr_t     rom_addr_o,
    output logic                    rom_ce_o,
    output cpu_pkg::inst_addr_t     id_pc_o,
    output cpu_pkg::inst_t          id_inst_o
);
    import cpu_pkg::*;

    inst_addr_t pc;
    inst_addr_t pc_next;

    // branch resolved in decode redirects after the delay slot
    assign pc_next = branch_taken_i ? branch_target_i : pc + 32'd4;
    assign rom_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc       <= RESET_PC;
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
            // no advance until the first real fetch has happened
            if (rom_ce_o && !stall_i) begin
                pc <= pc_next;
            end
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o <= pc;
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // operations that execute and memory still need to tell apart
    typedef enum logic [3:0] {
        OPER_NOP,
        OPER_ADDU,
        OPER_SUBU,
        OPER_AND,
        OPER_OR,
        OPER_XOR,
        OPER_SLT,
        OPER_LUI,
        OPER_LW,
        OPER_SW
    } oper_t;

    // primary opcodes, inst[31:26]
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes under SPECIAL, inst[5:0]
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

`default_nettype wire
